// File: source/cache_cfg_pkg.sv
package cache_cfg_pkg;

  // one data or address word on either port
  typedef logic [31:0] word_t;

  // address layout, 32 bits
  //   [31:6] tag
  //   [5:3]  set index
  //   [2]    word within block
  //   [1:0]  byte offset, always zero
  typedef logic [25:0] tag_t;

  // one of 8 sets
  typedef logic [2:0] set_idx_t;

  // word select inside a two-word block
  typedef logic word_sel_t;

  // frame number, {set, way}
  // way sits in the low bit so both ways of a set are neighbours
  typedef logic [3:0] frame_t;

  // two ways times eight sets
  localparam int NUM_FRAMES = 16;

  // zero bits below the word select on memory addresses
  localparam int BYTE_OFFSET_BITS = 2;

endpackage

// File: source/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

  // miss and flush controller states
  typedef enum logic [3:0] {
    IDLE,
    WB0,
    WB1,
    FILL0,
    FILL1,
    FLUSH_SCAN,
    FLUSH_WB0,
    FLUSH_WB1,
    DONE
  } ctrl_state_t;

  // what the controller is doing on the memory port
  // one-hot, bit 0 is read and bit 1 is write
  typedef enum logic [1:0] {
    MEM_NONE  = 2'b00,
    MEM_READ  = 2'b01,
    MEM_WRITE = 2'b10
  } mem_op_t;

endpackage

// File: source/array_ctrl_if.sv
`timescale 1ns/1ps

interface array_ctrl_if import cache_cfg_pkg::*; ();

  // frame and word the controller works on
  frame_t    frame;
  word_sel_t word;

  // refill path, data comes straight from memory
  logic      fill_we;
  word_t     fill_data;
  tag_t      fill_tag;
  // install tag, set valid, clear dirty
  logic      tag_we;

  // clear dirty after a flush write-back
  logic      clean;

  // lookups returned by the tag array
  frame_t    victim_frame;
  logic      victim_dirty;
  // tag of the selected frame, used to rebuild write-back addresses
  tag_t      victim_tag;
  logic      frame_dirty;

  // word at frame/word, for write-backs
  word_t     rd_word;

  modport fsm (
    output frame, word, fill_we, fill_data, fill_tag, tag_we, clean,
    input  victim_frame, victim_dirty, victim_tag, frame_dirty, rd_word
  );

  modport tags (
    input  frame, fill_tag, tag_we, clean,
    output victim_frame, victim_dirty, victim_tag, frame_dirty
  );

  modport data (
    input  frame, word, fill_we, fill_data,
    output rd_word
  );

endinterface

// File: source/tag_array.sv
`timescale 1ns/1ps

module tag_array import cache_cfg_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  tag_t      req_tag,
  input  set_idx_t  req_set,
  input  logic      write_hit,
  output logic      hit,
  output frame_t    hit_frame,
  array_ctrl_if.tags actl
);

  localparam int NUM_SETS = NUM_FRAMES / 2;

  // per-frame state
  tag_t                  tags [NUM_FRAMES];
  logic [NUM_FRAMES-1:0] valid;
  logic [NUM_FRAMES-1:0] dirty;

  // per set, the way to evict next
  logic [NUM_SETS-1:0]   lru;

  frame_t way0_frame;
  frame_t way1_frame;
  frame_t victim;
  logic   hit0;
  logic   hit1;

  // both candidate frames of the requested set
  assign way0_frame = {req_set, 1'b0};
  assign way1_frame = {req_set, 1'b1};

  // tag compare on each way
  assign hit0 = valid[way0_frame] && (tags[way0_frame] == req_tag);
  assign hit1 = valid[way1_frame] && (tags[way1_frame] == req_tag);

  assign hit       = hit0 | hit1;
  assign hit_frame = hit1 ? way1_frame : way0_frame;

  // victim is the lru way of the set, even if it is invalid
  assign victim            = {req_set, lru[req_set]};
  assign actl.victim_frame = victim;
  assign actl.victim_dirty = dirty[victim];

  // lookups on the frame the controller selects
  assign actl.victim_tag  = tags[actl.frame];
  assign actl.frame_dirty = dirty[actl.frame];

  // tag store, written only on refill
  always_ff @(posedge CLK)
  begin
    if (actl.tag_we)
    begin
      tags[actl.frame] <= actl.fill_tag;
    end
  end

  // valid, dirty and lru bits
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      valid <= '0;
      dirty <= '0;
      lru   <= '0;
    end
    else
    begin
      // a hit makes the other way the next victim
      if (hit)
      begin
        lru[req_set] <= ~hit_frame[0];
      end

      // store into a resident block
      if (write_hit)
      begin
        dirty[hit_frame] <= 1'b1;
      end

      // flush wrote this frame back
      if (actl.clean)
      begin
        dirty[actl.frame] <= 1'b0;
      end

      // refill done, block is clean and usable
      if (actl.tag_we)
      begin
        valid[actl.frame] <= 1'b1;
        dirty[actl.frame] <= 1'b0;
      end
    end
  end

endmodule

// File: source/data_array.sv
`timescale 1ns/1ps

module data_array import cache_cfg_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  frame_t    hit_frame,
  input  word_sel_t req_word,
  input  logic      write_hit,
  input  word_t     dstore,
  output word_t     dload,
  array_ctrl_if.data actl
);

  // two words per frame
  localparam int NUM_WORDS = NUM_FRAMES * 2;

  word_t words [NUM_WORDS];

  // word address is {frame, word select}
  logic [4:0] cpu_addr;
  logic [4:0] ctrl_addr;

  assign cpu_addr  = {hit_frame, req_word};
  assign ctrl_addr = {actl.frame, actl.word};

  // processor load, valid whenever the tags hit
  assign dload = words[cpu_addr];

  // controller side read for write-backs
  assign actl.rd_word = words[ctrl_addr];

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      words <= '{default: '0};
    end
    else
    begin
      // store hit, only ever in idle
      if (write_hit)
      begin
        words[cpu_addr] <= dstore;
      end

      // refill word from memory
      if (actl.fill_we)
      begin
        words[ctrl_addr] <= actl.fill_data;
      end
    end
  end

endmodule

// File: source/miss_flush_fsm.sv
`timescale 1ns/1ps

module miss_flush_fsm import cache_cfg_pkg::*, cache_ctrl_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     halt,
  input  logic     req_valid,
  input  logic     hit,
  input  tag_t     req_tag,
  input  set_idx_t req_set,
  output logic     mem_ren,
  output logic     mem_wen,
  output word_t    mem_addr,
  output word_t    mem_store,
  input  word_t    mem_load,
  input  logic     mem_wait,
  output logic     flushed,
  array_ctrl_if.fsm actl
);

  ctrl_state_t state;
  ctrl_state_t next_state;

  // frame picked at miss time
  frame_t victim_q;
  // flush walk position
  frame_t flush_cnt;

  mem_op_t   mem_op;
  frame_t    sel_frame;
  word_sel_t sel_word;
  set_idx_t  sel_set;
  word_t     wb_addr;
  word_t     fill_addr;
  logic      flush_mode;
  logic      flush_last;

  assign flush_mode = (state == FLUSH_SCAN) || (state == FLUSH_WB0) ||
                      (state == FLUSH_WB1);
  assign flush_last = (flush_cnt == frame_t'(NUM_FRAMES - 1));

  // frame and word on the array interface
  assign sel_frame = flush_mode ? flush_cnt : victim_q;
  assign sel_word  = (state == WB1) || (state == FILL1) || (state == FLUSH_WB1);
  // set index is the frame without its way bit
  assign sel_set   = sel_frame[3:1];

  // write-back address from the stored tag and the frame's own set
  assign wb_addr   = {actl.victim_tag, sel_set, sel_word, {BYTE_OFFSET_BITS{1'b0}}};
  // refill address from the held request
  assign fill_addr = {req_tag, req_set, sel_word, {BYTE_OFFSET_BITS{1'b0}}};

  assign actl.frame     = sel_frame;
  assign actl.word      = sel_word;
  assign actl.fill_data = mem_load;
  assign actl.fill_tag  = req_tag;
  // writes land only on the edge that completes the transfer
  assign actl.fill_we   = ((state == FILL0) || (state == FILL1)) && !mem_wait;
  assign actl.tag_we    = (state == FILL1) && !mem_wait;
  assign actl.clean     = (state == FLUSH_WB1) && !mem_wait;

  // memory operation per state
  always_comb
  begin
    case (state)
      WB0, WB1, FLUSH_WB0, FLUSH_WB1: mem_op = MEM_WRITE;
      FILL0, FILL1:                   mem_op = MEM_READ;
      default:                        mem_op = MEM_NONE;
    endcase
  end

  // strobes straight from the one-hot operation bits
  assign mem_ren   = mem_op[0];
  assign mem_wen   = mem_op[1];
  assign mem_addr  = mem_ren ? fill_addr : (mem_wen ? wb_addr : '0);
  assign mem_store = mem_wen ? actl.rd_word : '0;

  // sticky once the walk is over
  assign flushed = (state == DONE);

  always_comb
  begin
    next_state = state;
    case (state)
      IDLE:
      begin
        // halt wins over a pending miss
        if (halt)
        begin
          next_state = FLUSH_SCAN;
        end
        else if (req_valid && !hit)
        begin
          next_state = actl.victim_dirty ? WB0 : FILL0;
        end
      end
      WB0:        if (!mem_wait) next_state = WB1;
      WB1:        if (!mem_wait) next_state = FILL0;
      FILL0:      if (!mem_wait) next_state = FILL1;
      FILL1:      if (!mem_wait) next_state = IDLE;
      FLUSH_SCAN:
      begin
        if (actl.frame_dirty)
        begin
          next_state = FLUSH_WB0;
        end
        else if (flush_last)
        begin
          next_state = DONE;
        end
      end
      FLUSH_WB0:  if (!mem_wait) next_state = FLUSH_WB1;
      FLUSH_WB1:
      begin
        if (!mem_wait)
        begin
          next_state = flush_last ? DONE : FLUSH_SCAN;
        end
      end
      // stays here until reset
      DONE:       next_state = DONE;
      default:    next_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state     <= IDLE;
      victim_q  <= '0;
      flush_cnt <= '0;
    end
    else
    begin
      state <= next_state;

      // latch the victim as the miss is taken
      if ((state == IDLE) && !halt && req_valid && !hit)
      begin
        victim_q <= actl.victim_frame;
      end

      // walk starts at frame 0
      if ((state == IDLE) && halt)
      begin
        flush_cnt <= '0;
      end
      else if ((state == FLUSH_SCAN) && !actl.frame_dirty && !flush_last)
      begin
        flush_cnt <= flush_cnt + 1'b1;
      end
      else if ((state == FLUSH_WB1) && !mem_wait && !flush_last)
      begin
        flush_cnt <= flush_cnt + 1'b1;
      end
    end
  end

endmodule

// File: source/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import cache_cfg_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  // processor port
  input  logic  halt,
  input  logic  dren,
  input  logic  dwen,
  input  word_t daddr,
  input  word_t dstore,
  output logic  dhit,
  output word_t dload,
  // memory port
  output logic  mem_ren,
  output logic  mem_wen,
  output word_t mem_addr,
  output word_t mem_store,
  input  word_t mem_load,
  input  logic  mem_wait,
  output logic  flushed
);

  tag_t      req_tag;
  set_idx_t  req_set;
  word_sel_t req_word;
  logic      req_valid;
  logic      hit;
  logic      write_hit;
  frame_t    hit_frame;

  // address fields
  assign req_tag  = daddr[31:6];
  assign req_set  = daddr[5:3];
  assign req_word = daddr[2];

  assign req_valid = dren | dwen;
  // hit qualified by a live request
  assign dhit      = hit & req_valid;
  assign write_hit = hit & dwen;

  array_ctrl_if actl ();

  tag_array u_tags (
    .CLK       (CLK),
    .nRST      (nRST),
    .req_tag   (req_tag),
    .req_set   (req_set),
    .write_hit (write_hit),
    .hit       (hit),
    .hit_frame (hit_frame),
    .actl      (actl.tags)
  );

  data_array u_data (
    .CLK       (CLK),
    .nRST      (nRST),
    .hit_frame (hit_frame),
    .req_word  (req_word),
    .write_hit (write_hit),
    .dstore    (dstore),
    .dload     (dload),
    .actl      (actl.data)
  );

  miss_flush_fsm u_ctrl (
    .CLK       (CLK),
    .nRST      (nRST),
    .halt      (halt),
    .req_valid (req_valid),
    .hit       (hit),
    .req_tag   (req_tag),
    .req_set   (req_set),
    .mem_ren   (mem_ren),
    .mem_wen   (mem_wen),
    .mem_addr  (mem_addr),
    .mem_store (mem_store),
    .mem_load  (mem_load),
    .mem_wait  (mem_wait),
    .flushed   (flushed),
    .actl      (actl.fsm)
  );

endmodule

// File: testbench/dcache_tb_mem.sv
`timescale 1ns/1ps

module dcache_tb_mem import cache_cfg_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  mem_ren,
  input  logic  mem_wen,
  input  word_t mem_addr,
  input  word_t mem_store,
  output word_t mem_load,
  output logic  mem_wait
);

  // tags 0 to 3 cover byte addresses 0 to 255
  localparam int MEM_WORDS = 64;

  word_t      mem [MEM_WORDS];
  logic [1:0] waits_left;
  logic       req;
  logic [5:0] idx;

  assign req = mem_ren | mem_wen;
  assign idx = mem_addr[7:2];

  // wait stays high until the drawn count runs out
  assign mem_wait = req && (waits_left != 2'd0);
  assign mem_load = mem_ren ? mem[idx] : '0;

  // start image, word address xor a fixed pattern
  initial
  begin
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      mem[i] = word_t'(i * 4) ^ 32'hA5A5A5A5;
    end
  end

  // store lands on the completing edge
  always @(posedge CLK)
  begin
    if (mem_wen && !mem_wait)
      mem[idx] <= mem_store;
  end

  // wait counter, redrawn after each transfer
  always @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
      waits_left <= 2'd1;
    else if (req && mem_wait)
      waits_left <= waits_left - 2'd1;
    else if (req)
      waits_left <= 2'($urandom_range(0, 3));
  end

endmodule

// File: testbench/dcache_props.sv
`timescale 1ns/1ps

module dcache_props import cache_cfg_pkg::*, cache_ctrl_pkg::*; (
  input logic        CLK,
  input logic        nRST,
  input logic        mem_ren,
  input logic        mem_wen,
  input word_t       mem_addr,
  input word_t       mem_store,
  input logic        mem_wait,
  input logic        dhit,
  input logic        flushed,
  input ctrl_state_t state
);

  // failed checks so far, polled from the testbench
  int fail_count = 0;

  // one memory operation at a time
  a_one_op: assert property (@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen))
  else
  begin
    $error("mem_ren and mem_wen high together");
    fail_count++;
  end

  // request held steady through wait cycles
  a_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (mem_ren || mem_wen) && mem_wait |=>
      $stable(mem_ren) && $stable(mem_wen) && $stable(mem_addr) && $stable(mem_store))
  else
  begin
    $error("memory request changed while mem_wait was high");
    fail_count++;
  end

  // sticky until reset
  a_flushed: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
  else
  begin
    $error("flushed fell without a reset");
    fail_count++;
  end

  // hits only while idle
  a_hit_idle: assert property (@(posedge CLK) disable iff (!nRST) (state != IDLE) |-> !dhit)
  else
  begin
    $error("dhit high outside IDLE");
    fail_count++;
  end

endmodule

bind dcache_top dcache_props u_props (
  .CLK       (CLK),
  .nRST      (nRST),
  .mem_ren   (mem_ren),
  .mem_wen   (mem_wen),
  .mem_addr  (mem_addr),
  .mem_store (mem_store),
  .mem_wait  (mem_wait),
  .dhit      (dhit),
  .flushed   (flushed),
  .state     (u_ctrl.state)
);

// File: testbench/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb import cache_cfg_pkg::*; ();

  localparam int CLK_PERIOD   = 8;
  localparam int SEED         = 32'h7111;
  localparam int NUM_REQ      = 400;
  localparam int NUM_DIRECTED = 12;
  localparam int MAX_TAG      = 3;
  localparam int MEM_WORDS    = 64;
  // worst miss is two write-backs and two refills, three waits each
  localparam int REQ_CYCLES   = 40;
  // scan cycle plus two slow writes per frame, then the hold check
  localparam int FLUSH_CYCLES = 16 * 10 + 40;
  localparam int TIMEOUT_CYCLES = (NUM_REQ + NUM_DIRECTED) * REQ_CYCLES + FLUSH_CYCLES + 10;

  logic  CLK = 1'b0;
  logic  nRST;
  logic  halt;
  logic  dren;
  logic  dwen;
  word_t daddr;
  word_t dstore;
  word_t dload;
  logic  dhit;
  logic  mem_ren;
  logic  mem_wen;
  word_t mem_addr;
  word_t mem_store;
  word_t mem_load;
  logic  mem_wait;
  logic  flushed;

  // reference image of memory and first touch per block
  word_t model [MEM_WORDS];
  logic  touched [MEM_WORDS/2];
  int    error_count = 0;

  always #(CLK_PERIOD/2) CLK = ~CLK;

  dcache_top UUT (.*);
  dcache_tb_mem u_mem (.*);

  // word before any write
  function automatic word_t initial_word(input word_t addr);
    return addr ^ 32'hA5A5A5A5;
  endfunction

  // tag, set, word select, zero byte offset
  function automatic word_t make_addr(input int tag, input int set, input int word);
    return word_t'((tag << 6) | (set << 3) | (word << 2));
  endfunction

  task automatic stop_with_failure();
    $display("Regression failed");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_value(input word_t got, input word_t exp, input string what);
    if (got !== exp)
    begin
      error_count++;
      $display("ERROR at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  // one processor access, held until dhit
  task automatic access(input logic is_write, input word_t addr, input word_t data);
    word_t rdata;
    logic  saw_read;
    int    idx;
    idx = addr[7:2];
    saw_read = 1'b0;
    @(posedge CLK);
    dren   <= ~is_write;
    dwen   <= is_write;
    daddr  <= addr;
    dstore <= data;
    @(negedge CLK);
    while (!dhit)
    begin
      saw_read = saw_read | mem_ren;
      @(negedge CLK);
    end
    rdata = dload;
    // write commits on this edge
    @(posedge CLK);
    dren <= 1'b0;
    dwen <= 1'b0;
    // cold block has to come from memory
    if (!touched[idx/2])
      check_value(word_t'(saw_read), 32'd1, $sformatf("first access of %h missed no read", addr));
    touched[idx/2] = 1'b1;
    if (is_write)
      model[idx] = data;
    else
      check_value(rdata, model[idx], $sformatf("read of %h", addr));
  endtask

  // bound assertions end the run too
  always @(negedge CLK)
  begin
    if (UUT.u_props.fail_count != 0)
    begin
      $display("a bound assertion on the cache failed");
      stop_with_failure();
    end
  end

  initial
  begin
    word_t addr;
    void'($urandom(SEED));
    nRST   = 1'b0;
    halt   = 1'b0;
    dren   = 1'b0;
    dwen   = 1'b0;
    daddr  = '0;
    dstore = '0;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      model[i] = initial_word(word_t'(i * 4));
      touched[i/2] = 1'b0;
    end
    repeat (3) @(posedge CLK);
    nRST <= 1'b1;
    // quiet outputs after reset
    @(negedge CLK);
    check_value(word_t'({mem_ren, mem_wen, dhit, flushed}), 32'd0, "outputs busy after reset");

    // three tags in set 5, dirty blocks get evicted
    for (int i = 0; i < 6; i++)
      access(1'b1, make_addr(i % 3, 5, i / 3), $urandom);
    for (int i = 0; i < 6; i++)
      access(1'b0, make_addr(i % 3, 5, i / 3), 32'd0);

    // random mix over four tags
    for (int n = 0; n < NUM_REQ; n++)
    begin
      addr = make_addr($urandom_range(0, MAX_TAG), $urandom_range(0, 7), $urandom_range(0, 1));
      access(1'($urandom_range(0, 1)), addr, $urandom);
    end

    // flush walk
    @(posedge CLK);
    halt <= 1'b1;
    @(negedge CLK);
    while (!flushed)
      @(negedge CLK);
    repeat (20)
    begin
      @(negedge CLK);
      check_value(word_t'(flushed), 32'd1, "flushed dropped after the flush");
    end
    // every dirty word should be back in memory
    for (int i = 0; i < MEM_WORDS; i++)
      check_value(u_mem.mem[i], model[i], $sformatf("memory at %h after flush", i * 4));

    if (error_count == 0)
    begin
      $display("Regression passed");
      $finish;
    end
    else
      stop_with_failure();
  end

  // watchdog
  initial
  begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("TIMEOUT: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    stop_with_failure();
  end

endmodule

// File: files.f
source/cache_cfg_pkg.sv
source/cache_ctrl_pkg.sv
source/array_ctrl_if.sv
source/tag_array.sv
source/data_array.sv
source/miss_flush_fsm.sv
source/dcache_top.sv
testbench/dcache_tb_mem.sv
testbench/dcache_props.sv
testbench/dcache_tb.sv
